/* hdl/glyph_pkg.sv */
package glyph_pkg;

	// frame buffer geometry
	localparam int X_W = 8;
	localparam int Y_W = 7;
	localparam int COLOR_W = 3;

	localparam int NUM_GLYPHS = 6;
	localparam int MAX_STROKES = 4;
	localparam int SIDX_W = $clog2(MAX_STROKES);
	localparam int LEN_W = 4;
	localparam int OFS_W = 5; // signed offset from the anchor

	localparam logic [X_W-1:0] ORIGIN_X = 8'd79; // middle of the screen
	localparam logic [Y_W-1:0] ORIGIN_Y = 7'd63;
	localparam logic [COLOR_W-1:0] ERASE_COLOR = 3'b000;
	localparam logic [3:0] LFSR_SEED = 4'b1110;

	typedef enum logic [2:0] {
		GLYPH_UP    = 3'd0,
		GLYPH_DOWN  = 3'd1,
		GLYPH_LEFT  = 3'd2,
		GLYPH_RIGHT = 3'd3,
		GLYPH_L     = 3'd4,
		GLYPH_R     = 3'd5
	} glyph_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DRAW,
		ST_SHOWN,
		ST_ERASE
	} seq_state_e;

	typedef struct packed {
		logic [X_W-1:0] x;
		logic [Y_W-1:0] y;
	} point_t;

	typedef struct packed {
		point_t pt;
		logic [COLOR_W-1:0] color;
	} pixel_t;

	// start point is relative to ORIGIN_X/ORIGIN_Y, steps are -1, 0 or +1
	typedef struct packed {
		logic signed [OFS_W-1:0] x0;
		logic signed [OFS_W-1:0] y0;
		logic signed [1:0] dx;
		logic signed [1:0] dy;
		logic [LEN_W-1:0] len;
	} stroke_t;

	localparam logic [COLOR_W-1:0] GLYPH_COLOR [NUM_GLYPHS] = '{
		3'b111, 3'b001, 3'b010, 3'b011, 3'b101, 3'b100
	};

	localparam logic [SIDX_W:0] GLYPH_NSTROKES [NUM_GLYPHS] = '{
		3'd3, 3'd3, 3'd3, 3'd3, 3'd2, 3'd4
	};

	// y grows downwards on the screen
	localparam stroke_t GLYPH_STROKES [NUM_GLYPHS][MAX_STROKES] = '{
		'{ // up
			'{5'sd0, 5'sd0, 2'sd0, -2'sd1, 4'd8},
			'{-5'sd1, -5'sd6, -2'sd1, 2'sd1, 4'd3},
			'{5'sd1, -5'sd6, 2'sd1, 2'sd1, 4'd3},
			'0
		},
		'{ // down
			'{5'sd0, 5'sd0, 2'sd0, 2'sd1, 4'd8},
			'{-5'sd1, 5'sd6, -2'sd1, -2'sd1, 4'd3},
			'{5'sd1, 5'sd6, 2'sd1, -2'sd1, 4'd3},
			'0
		},
		'{ // left
			'{5'sd0, 5'sd0, -2'sd1, 2'sd0, 4'd8},
			'{-5'sd6, -5'sd1, 2'sd1, -2'sd1, 4'd3},
			'{-5'sd6, 5'sd1, 2'sd1, 2'sd1, 4'd3},
			'0
		},
		'{ // right
			'{5'sd0, 5'sd0, 2'sd1, 2'sd0, 4'd8},
			'{5'sd6, -5'sd1, -2'sd1, -2'sd1, 4'd3},
			'{5'sd6, 5'sd1, -2'sd1, 2'sd1, 4'd3},
			'0
		},
		'{ // L, stem then foot
			'{5'sd0, -5'sd7, 2'sd0, 2'sd1, 4'd8},
			'{5'sd1, 5'sd0, 2'sd1, 2'sd0, 4'd4},
			'0,
			'0
		},
		'{ // R, stem, bowl in two halves, leg
			'{5'sd0, 5'sd0, 2'sd0, 2'sd1, 4'd8},
			'{5'sd1, 5'sd0, 2'sd1, 2'sd1, 4'd2},
			'{5'sd2, 5'sd2, -2'sd1, 2'sd1, 4'd2},
			'{5'sd1, 5'sd4, 2'sd1, 2'sd1, 4'd4}
		}
	};

endpackage

/* hdl/glyph_picker.sv */
`timescale 1ns/1ps

module glyph_picker (
	input  logic clk,
	input  logic reset_n,
	output glyph_pkg::glyph_e pick
);
	import glyph_pkg::*;

	logic [3:0] lfsr;

	// x^4 + x^3 + 1, never reaches zero from the seed
	always_ff @(posedge clk)
	begin
		if (!reset_n)
			lfsr <= LFSR_SEED;
		else
			lfsr <= {lfsr[2:0], lfsr[2] ^ lfsr[3]};
	end

	// uneven bands, so some glyphs come up more often
	always_comb
	begin
		if (lfsr < 4'd3)
			pick = GLYPH_UP;
		else if (lfsr < 4'd6)
			pick = GLYPH_DOWN;
		else if (lfsr < 4'd9)
			pick = GLYPH_LEFT;
		else if (lfsr < 4'd11)
			pick = GLYPH_RIGHT;
		else if (lfsr < 4'd13)
			pick = GLYPH_L;
		else
			pick = GLYPH_R;
	end

endmodule

/* hdl/draw_sequencer.sv */
`timescale 1ns/1ps

module draw_sequencer #(
	parameter int unsigned FRAME_DIV = 3125000
) (
	input  logic clk,
	input  logic reset_n,
	input  logic change_instruction,
	input  logic clear_instruction,
	input  glyph_pkg::glyph_e pick,
	input  logic [glyph_pkg::NUM_GLYPHS-1:0] done,
	output logic [glyph_pkg::NUM_GLYPHS-1:0] start,
	output logic tick,
	output glyph_pkg::glyph_e sel,
	output logic erase
);
	import glyph_pkg::*;

	localparam int DIV_W = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;

	seq_state_e state;
	logic [DIV_W-1:0] div_cnt;
	logic launch; // a drawer is started this cycle
	logic wrap;

	assign launch = ((state == ST_IDLE) && change_instruction) ||
		((state == ST_SHOWN) && clear_instruction);
	assign wrap = (div_cnt == DIV_W'(FRAME_DIV - 1));

	// request FSM
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state <= ST_IDLE;
			sel <= GLYPH_UP;
			erase <= 1'b0;
			start <= '0;
		end
		else
		begin
			start <= '0; // one cycle pulse
			case (state)
				ST_IDLE:
				begin
					if (change_instruction)
					begin
						sel <= pick;
						erase <= 1'b0;
						start <= NUM_GLYPHS'(1) << pick;
						state <= ST_DRAW;
					end
				end
				ST_DRAW:
				begin
					if (done[sel])
						state <= ST_SHOWN;
				end
				ST_SHOWN:
				begin
					if (clear_instruction)
					begin
						erase <= 1'b1; // same glyph again, in black
						start <= NUM_GLYPHS'(1) << sel;
						state <= ST_ERASE;
					end
				end
				ST_ERASE:
				begin
					if (done[sel])
						state <= ST_IDLE;
				end
			endcase
		end
	end

	// frame divider, realigned on every launch
	// first tick lands FRAME_DIV cycles after the request
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			div_cnt <= '0;
			tick <= 1'b0;
		end
		else
		begin
			tick <= !launch && wrap;
			if (launch)
				div_cnt <= DIV_W'(1);
			else if (wrap)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

/* hdl/glyph_drawer.sv */
`timescale 1ns/1ps

module glyph_drawer #(
	parameter glyph_pkg::glyph_e GLYPH = glyph_pkg::GLYPH_UP
) (
	input  logic clk,
	input  logic reset_n,
	input  logic start,
	input  logic tick,
	output glyph_pkg::point_t point,
	output logic point_valid,
	output logic done
);
	import glyph_pkg::*;

	localparam logic [SIDX_W-1:0] LAST_IDX = SIDX_W'(GLYPH_NSTROKES[GLYPH] - 1);

	logic active;
	logic [SIDX_W-1:0] sidx; // current stroke
	logic [LEN_W-1:0] remain; // pixels left in this stroke
	point_t cur;
	stroke_t cur_stroke;
	stroke_t next_stroke;

	// anchor plus signed offset
	function automatic point_t stroke_origin(input stroke_t s);
		point_t p;
		p.x = ORIGIN_X + X_W'(s.x0);
		p.y = ORIGIN_Y + Y_W'(s.y0);
		return p;
	endfunction

	assign cur_stroke = GLYPH_STROKES[GLYPH][sidx];
	assign next_stroke = GLYPH_STROKES[GLYPH][sidx + 1'b1];

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			active <= 1'b0;
			sidx <= '0;
			remain <= '0;
			point_valid <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			point_valid <= 1'b0;
			done <= point_valid & ~active; // final point went out last cycle
			if (start)
			begin
				active <= 1'b1;
				sidx <= '0;
				remain <= GLYPH_STROKES[GLYPH][0].len;
			end
			else if (active && tick)
			begin
				point_valid <= 1'b1;
				if (remain == LEN_W'(1))
				begin
					if (sidx == LAST_IDX)
						active <= 1'b0;
					else
					begin
						sidx <= sidx + 1'b1;
						remain <= next_stroke.len;
					end
				end
				else
					remain <= remain - 1'b1;
			end
		end
	end

	// point walk
	always_ff @(posedge clk)
	begin
		if (start)
			cur <= stroke_origin(GLYPH_STROKES[GLYPH][0]);
		else if (active && tick)
		begin
			point <= cur;
			if (remain == LEN_W'(1))
				cur <= stroke_origin(next_stroke); // unused after the last stroke
			else
			begin
				cur.x <= cur.x + X_W'(cur_stroke.dx);
				cur.y <= cur.y + Y_W'(cur_stroke.dy);
			end
		end
	end

endmodule

/* hdl/pixel_mux.sv */
`timescale 1ns/1ps

module pixel_mux (
	input  logic clk,
	input  logic reset_n,
	input  glyph_pkg::point_t [glyph_pkg::NUM_GLYPHS-1:0] points,
	input  logic [glyph_pkg::NUM_GLYPHS-1:0] valids,
	input  glyph_pkg::glyph_e sel,
	input  logic erase,
	output glyph_pkg::pixel_t pixel,
	output logic plot
);
	import glyph_pkg::*;

	logic hit; // selected drawer has a point

	assign hit = valids[sel];

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			plot <= 1'b0;
			pixel <= '0;
		end
		else
		begin
			plot <= hit;
			// pixel holds its last value between plots
			if (hit)
			begin
				pixel.pt <= points[sel];
				pixel.color <= erase ? ERASE_COLOR : GLYPH_COLOR[sel];
			end
		end
	end

endmodule

/* hdl/glyph_ui_top.sv */
`timescale 1ns/1ps

module glyph_ui_top #(
	parameter int unsigned FRAME_DIV = 3125000 // 50 MHz down to 16 ticks per second
) (
	input  logic clk,
	input  logic reset_n,
	input  logic change_instruction,
	input  logic clear_instruction,
	output glyph_pkg::pixel_t pixel,
	output logic plot
);
	import glyph_pkg::*;

	glyph_e pick;
	glyph_e sel;
	logic erase;
	logic tick;
	logic [NUM_GLYPHS-1:0] start;
	logic [NUM_GLYPHS-1:0] done;
	logic [NUM_GLYPHS-1:0] valids;
	point_t [NUM_GLYPHS-1:0] points;

	glyph_picker picker_i (
		.clk     (clk),
		.reset_n (reset_n),
		.pick    (pick)
	);

	draw_sequencer #(
		.FRAME_DIV (FRAME_DIV)
	) seq_i (
		.clk                (clk),
		.reset_n            (reset_n),
		.change_instruction (change_instruction),
		.clear_instruction  (clear_instruction),
		.pick               (pick),
		.done               (done),
		.start              (start),
		.tick               (tick),
		.sel                (sel),
		.erase              (erase)
	);

	// one drawer per glyph, drawing and erasing share it
	for (genvar i = 0; i < NUM_GLYPHS; i++)
	begin : g_drawer
		glyph_drawer #(
			.GLYPH (glyph_e'(i))
		) drawer_i (
			.clk         (clk),
			.reset_n     (reset_n),
			.start       (start[i]),
			.tick        (tick),
			.point       (points[i]),
			.point_valid (valids[i]),
			.done        (done[i])
		);
	end

	pixel_mux mux_i (
		.clk     (clk),
		.reset_n (reset_n),
		.points  (points),
		.valids  (valids),
		.sel     (sel),
		.erase   (erase),
		.pixel   (pixel),
		.plot    (plot)
	);

endmodule

/* sim/glyph_ui_tb.sv */
`timescale 1ns/1ps

module glyph_ui_tb;
	import glyph_pkg::*;

	localparam int FRAME_DIV = 4;
	localparam int NUM_PAIRS = 12;
	localparam int NUM_ROWS = 5 + 2 * (NUM_PAIRS - 1);
	localparam int QUIET_CYCLES = 40;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * (16 * 4 + 20) * 2;

	typedef enum logic [1:0] {
		ACT_WAIT,
		ACT_CHANGE,
		ACT_CLEAR
	} action_e;

	typedef enum logic [1:0] {
		EXP_NONE,
		EXP_DRAW,
		EXP_ERASE
	} outcome_e;

	typedef struct packed {
		action_e action;
		logic [7:0] gap; // idle cycles before the action
		outcome_e outcome;
	} row_t;

	logic clk;
	logic reset_n;
	logic change_instruction;
	logic clear_instruction;
	pixel_t pixel;
	logic plot;

	integer seed;
	int cycle_cnt = 0;
	int exp_len; // sum of stroke lengths
	logic drawn_yet; // a change request has been sent
	glyph_e cur_glyph;
	point_t exp_pts[$];
	row_t table_rows[$];

	glyph_ui_top #(
		.FRAME_DIV (FRAME_DIV)
	) dut_i (
		.clk                (clk),
		.reset_n            (reset_n),
		.change_instruction (change_instruction),
		.clear_instruction  (clear_instruction),
		.pixel              (pixel),
		.plot               (plot)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// run limit
	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the test did not reach its end", cycle_cnt);
			$display("Regression failed");
			$fatal(1, "run stopped");
		end
	end

	task automatic report_mismatch(input string msg);
		$display("FAIL at %0t ns: %s", $time, msg);
		$display("Regression failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic report_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_pixel(input pixel_t got, input pixel_t exp);
		if (got !== exp)
			report_mismatch($sformatf("pixel x=%0d y=%0d c=%b, expected x=%0d y=%0d c=%b",
				got.pt.x, got.pt.y, got.color, exp.pt.x, exp.pt.y, exp.color));
	endtask

	task automatic check_glyph(input glyph_e got);
		if (got > GLYPH_R)
			report_mismatch($sformatf("glyph code %0d is not a legal glyph", got));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	// outputs settle well before this point
	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic add_row(input action_e act, input outcome_e res);
		row_t row;
		row.action = act;
		row.gap = 8'(2 + ({$random(seed)} % 8));
		row.outcome = res;
		table_rows.push_back(row);
	endtask

	task automatic build_table();
		add_row(ACT_WAIT, EXP_NONE); // quiet after reset
		add_row(ACT_CLEAR, EXP_NONE); // nothing on screen yet
		add_row(ACT_CHANGE, EXP_DRAW);
		add_row(ACT_CHANGE, EXP_NONE); // glyph still shown
		add_row(ACT_CLEAR, EXP_ERASE);
		for (int p = 1; p < NUM_PAIRS; p++)
		begin
			add_row(ACT_CHANGE, EXP_DRAW);
			add_row(ACT_CLEAR, EXP_ERASE);
		end
	endtask

	// reference point list built from the stroke tables
	task automatic expand_glyph(input glyph_e g);
		stroke_t st;
		point_t p;
		int x;
		int y;
		exp_pts.delete();
		exp_len = 0;
		for (int s = 0; s < int'(GLYPH_NSTROKES[g]); s++)
		begin
			st = GLYPH_STROKES[g][s];
			exp_len += int'(st.len);
			x = int'(ORIGIN_X) + int'($signed(st.x0));
			y = int'(ORIGIN_Y) + int'($signed(st.y0));
			for (int k = 0; k < int'(st.len); k++)
			begin
				p.x = X_W'(x + k * int'($signed(st.dx)));
				p.y = Y_W'(y + k * int'($signed(st.dy)));
				exp_pts.push_back(p);
			end
		end
	endtask

	task automatic watch_quiet(input int n);
		int plots;
		pixel_t zero_px;
		plots = 0;
		zero_px = '0;
		for (int k = 0; k < n; k++)
		begin
			next_cycle();
			if (plot)
				plots++;
			if (!drawn_yet)
				check_pixel(pixel, zero_px);
		end
		check_count(plots, 0, "plots while idle");
	endtask

	task automatic send_request(input logic is_change);
		change_instruction = is_change;
		clear_instruction = !is_change;
		next_cycle();
		change_instruction = 1'b0;
		clear_instruction = 1'b0;
	endtask

	task automatic collect_glyph(input logic erasing);
		int idx;
		int got;
		int waited;
		int last_cyc;
		logic [COLOR_W-1:0] col;
		pixel_t exp_px;
		waited = 0;
		// first plot at most FRAME_DIV+2 cycles after the request
		while (!plot)
		begin
			if (waited >= FRAME_DIV + 2)
				report_error("no pixel was plotted after the request");
			next_cycle();
			waited++;
		end
		if (!erasing)
		begin
			// colour tells which glyph was picked
			idx = -1;
			for (int g = 0; g < NUM_GLYPHS; g++)
				if (pixel.color == GLYPH_COLOR[g])
					idx = g;
			cur_glyph = glyph_e'(idx);
			check_glyph(cur_glyph);
			expand_glyph(cur_glyph);
			col = GLYPH_COLOR[cur_glyph];
		end
		else
			col = ERASE_COLOR; // same point list as the draw
		last_cyc = cycle_cnt;
		for (int n = 0; n < exp_pts.size(); n++)
		begin
			if (n > 0)
			begin
				waited = 0;
				do
				begin
					next_cycle();
					waited++;
				end while (!plot && waited < 2 * FRAME_DIV);
				if (!plot)
					report_error($sformatf("glyph stopped after %0d of %0d pixels",
						n, exp_pts.size()));
				check_count(cycle_cnt - last_cyc, FRAME_DIV, "cycles between plots");
			end
			exp_px.pt = exp_pts[n];
			exp_px.color = col;
			check_pixel(pixel, exp_px);
			last_cyc = cycle_cnt;
		end
		// any plot here would make the glyph too long
		got = exp_pts.size();
		for (int k = 0; k < 2 * FRAME_DIV + 2; k++)
		begin
			next_cycle();
			if (plot)
				got++;
		end
		check_count(got, exp_len, "pixel count of the glyph");
	endtask

	initial
	begin
		row_t row;
		reset_n = 1'b0;
		change_instruction = 1'b0;
		clear_instruction = 1'b0;
		seed = 32'h0ea25134;
		drawn_yet = 1'b0;
		cur_glyph = GLYPH_UP;
		build_table();
		repeat (2) @(posedge clk);
		#10;
		reset_n = 1'b1;

		for (int r = 0; r < table_rows.size(); r++)
		begin
			row = table_rows[r];
			watch_quiet(int'(row.gap));
			case (row.action)
				ACT_CHANGE:
				begin
					drawn_yet = 1'b1;
					send_request(1'b1);
				end
				ACT_CLEAR:
					send_request(1'b0);
				default:
					next_cycle();
			endcase
			case (row.outcome)
				EXP_DRAW:
					collect_glyph(1'b0);
				EXP_ERASE:
					collect_glyph(1'b1);
				default:
					watch_quiet(QUIET_CYCLES);
			endcase
		end

		$display("Regression passed");
		$finish;
	end

endmodule

/* flist.f */
hdl/glyph_pkg.sv
hdl/glyph_picker.sv
hdl/draw_sequencer.sv
hdl/glyph_drawer.sv
hdl/pixel_mux.sv
hdl/glyph_ui_top.sv
sim/glyph_ui_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal -j 0
TOP = glyph_ui_tb
FLIST = flist.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
